// ==== bench/udma_cases.txt ====
# Columns: op a b c, numbers in hex. W addr data, R addr expect, B ch word, D cycles,
# E ch l2_addr word, V ch events, F ch stalled_words (checks the stall, then drops them)
# Register readback on channel 0 while idle
W 0 0100
W 1 0010
R 0 0100
R 1 0010
W 2 1
R 2 1
W 2 0
R 2 0
R 3 0
# Single transfer of four words on channel 0
W 2 10
R 2 10
B 0 a0000000
B 0 a0000001
E 0 0100 a0000000
E 0 0104 a0000001
V 0 0
R 3 8
B 0 a0000002
B 0 a0000003
E 0 0108 a0000002
E 0 010c a0000003
V 0 1
R 2 0
R 3 0
B 0 a00000ff
D 10
F 0 1
# Continuous mode on channel 1, two passes of two words
W 4 1200
W 5 8
W 6 11
B 1 b0000000
B 1 b0000001
B 1 b0000002
B 1 b0000003
E 1 1200 b0000000
E 1 1204 b0000001
E 1 1200 b0000002
E 1 1204 b0000003
V 1 2
R 6 11
R 7 8
W 6 40
R 6 0
R 7 0
# All four channels at once
W 1 8
W 8 2300
W 9 8
W c 3400
W d 8
B 0 d0000000
B 0 d0000001
B 1 d1000000
B 1 d1000001
B 2 d2000000
B 2 d2000001
B 3 d3000000
B 3 d3000001
E 0 0100 d0000000
E 0 0104 d0000001
E 1 1200 d1000000
E 1 1204 d1000001
E 2 2300 d2000000
E 2 2304 d2000001
E 3 3400 d3000000
E 3 3404 d3000001
W 2 10
W 6 10
W a 10
W e 10
V 0 1
V 1 1
V 2 1
V 3 1
# Clear in the middle of a transfer on channel 2
W 9 20
W a 10
B 2 c0000000
B 2 c0000001
E 2 2300 c0000000
E 2 2304 c0000001
V 2 0
R b 18
W a 40
R a 0
R b 0
B 2 c00000ff
D 10
F 2 1

// ==== list.f ====
+incdir+rtl
rtl/udma_pkg.sv
rtl/udma_cfg_regs.sv
rtl/udma_rx_channel.sv
rtl/udma_l2_arbiter.sv
rtl/udma_core.sv
bench/tb_udma_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_udma_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_udma_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "udma_defines.svh"

module tb_udma_core;

    localparam int N_CH = `UDMA_N_CH;

    logic                                 clk;
    logic                                 reset;
    logic                                 cfg_valid;
    logic                                 cfg_rwn;
    udma_pkg::cfg_addr_t                  cfg_addr;
    udma_pkg::word_t                      cfg_wdata;
    logic                                 cfg_ready;
    udma_pkg::word_t                      cfg_rdata;
    logic [N_CH-1:0]                      rx_valid;
    udma_pkg::word_t [N_CH-1:0]           rx_data;
    logic [N_CH-1:0]                      rx_ready;
    logic [N_CH-1:0]                      events;
    logic                                 l2_req;
    udma_pkg::l2_addr_t                   l2_addr;
    udma_pkg::word_t                      l2_wdata;
    logic                                 l2_gnt;

    // Words waiting at each peripheral and the L2 writes each channel still owes
    udma_pkg::word_t                      rx_words [N_CH][$];
    udma_pkg::l2_addr_t                   exp_addr [N_CH][$];
    udma_pkg::word_t                      exp_data [N_CH][$];
    int                                   event_cnt [N_CH];

    logic [7:0]                           op_code [$];
    logic [31:0]                          op_a [$];
    logic [31:0]                          op_b [$];
    logic [31:0]                          op_c [$];

    logic [31:0]                          rng;
    int                                   cycles;
    int                                   cycle_limit;
    logic                                 l2_waiting;
    udma_pkg::l2_addr_t                   held_addr;
    udma_pkg::word_t                      held_data;

    udma_core i_dut (
        .sys_clk_i   ( clk       ),
        .reset_i     ( reset     ),
        .cfg_valid_i ( cfg_valid ),
        .cfg_rwn_i   ( cfg_rwn   ),
        .cfg_addr_i  ( cfg_addr  ),
        .cfg_wdata_i ( cfg_wdata ),
        .cfg_ready_o ( cfg_ready ),
        .cfg_rdata_o ( cfg_rdata ),
        .rx_valid_i  ( rx_valid  ),
        .rx_data_i   ( rx_data   ),
        .rx_ready_o  ( rx_ready  ),
        .events_o    ( events    ),
        .l2_req_o    ( l2_req    ),
        .l2_addr_o   ( l2_addr   ),
        .l2_wdata_o  ( l2_wdata  ),
        .l2_gnt_i    ( l2_gnt    )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            stop_run($sformatf("** Error at time %0t: %s: got 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
        end
    endtask

    // One register access, held until the DUT answers with ready
    task automatic reg_access(input logic rwn, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_rwn   <= rwn;
        cfg_addr  <= addr[3:0];
        cfg_wdata <= wdata;
        do
        begin
            @(posedge clk);
        end
        while (!cfg_ready);
        rdata = cfg_rdata;
        cfg_valid <= 1'b0;
        @(negedge clk);
    endtask

    // Leaves time for the event that follows the last grant to be counted
    task automatic wait_writes(input udma_pkg::ch_idx_t ch);
        while (exp_addr[ch].size() != 0)
        begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit)
        begin
            stop_run($sformatf("Timed out after %0d cycles waiting for the DUT", cycles));
        end
    end

    ////////////////////////////////////////////////////////////
    // Peripheral drivers, L2 responder and monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        udma_pkg::ch_idx_t ch;
        logic              acc;
        if (!reset)
        begin
            if (l2_waiting)
            begin
                check("l2_req_o held", 32'(l2_req), 32'd1);
                check("l2_addr_o held", 32'(l2_addr), 32'(held_addr));
                check("l2_wdata_o held", l2_wdata, held_data);
            end
            if (l2_req && l2_gnt)
            begin
                ch = l2_addr[13:12];
                if (exp_addr[ch].size() == 0)
                begin
                    stop_run($sformatf("Unexpected L2 write to 0x%04h from channel %0d",
                                       l2_addr, ch));
                end
                else
                begin
                    check("L2 address", 32'(l2_addr), 32'(exp_addr[ch][0]));
                    check("L2 data", l2_wdata, exp_data[ch][0]);
                    void'(exp_addr[ch].pop_front());
                    void'(exp_data[ch].pop_front());
                end
            end
            l2_waiting = l2_req && !l2_gnt;
            held_addr  = l2_addr;
            held_data  = l2_wdata;
            rng = xorshift32(rng);
            l2_gnt <= rng[0];

            for (int c = 0; c < N_CH; c++)
            begin
                if (events[c])
                begin
                    event_cnt[c]++;
                end
                acc = rx_valid[c] && rx_ready[c];
                if (acc && rx_words[c].size() != 0)
                begin
                    void'(rx_words[c].pop_front());
                end
                rng = xorshift32(rng);
                // A word on offer stays put until taken, new words come after random gaps
                if (rx_words[c].size() != 0 && ((rx_valid[c] && !acc) || rng[4]))
                begin
                    rx_valid[c] <= 1'b1;
                    rx_data[c]  <= rx_words[c][0];
                end
                else
                begin
                    rx_valid[c] <= 1'b0;
                end
            end
        end
    end

    initial
    begin
        int                fd;
        int                cnt;
        int                chr;
        int                limit;
        logic [7:0]        op;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       c;
        logic [31:0]       rdata;
        udma_pkg::ch_idx_t ch;

        reset       = 1'b1;
        cfg_valid   = 1'b0;
        cfg_rwn     = 1'b1;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        rx_valid    = '0;
        rx_data     = '0;
        l2_gnt      = 1'b0;
        rng         = 32'h05072108;
        cycles      = 0;
        cycle_limit = 0;
        l2_waiting  = 1'b0;
        held_addr   = '0;
        held_data   = '0;
        for (int k = 0; k < N_CH; k++)
        begin
            event_cnt[k] = 0;
        end

        fd = $fopen("bench/udma_cases.txt", "r");
        if (fd == 0)
        begin
            stop_run("Could not open bench/udma_cases.txt");
        end
        limit = 50;
        while ($fscanf(fd, " %c", op) == 1)
        begin
            if (op == "#")
            begin
                chr = $fgetc(fd);
                while (chr != 10 && chr != -1)
                begin
                    chr = $fgetc(fd);
                end
            end
            else
            begin
                a = '0;
                b = '0;
                c = '0;
                case (op)
                    "E":     cnt = $fscanf(fd, "%h %h %h", a, b, c);
                    "D":     cnt = $fscanf(fd, "%h", a);
                    default: cnt = $fscanf(fd, "%h %h", a, b);
                endcase
                if (cnt < 1)
                begin
                    stop_run("Malformed line in the cases file");
                end
                op_code.push_back(op);
                op_a.push_back(a);
                op_b.push_back(b);
                op_c.push_back(c);
                limit = limit + 20;
                if (op == "B")
                begin
                    limit = limit + 40;
                end
                if (op == "D")
                begin
                    limit = limit + int'(a);
                end
            end
        end
        $fclose(fd);
        cycle_limit = limit;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Each operation returns on a falling edge, so queue updates stay clear of the drivers
        for (int i = 0; i < op_code.size(); i++)
        begin
            a  = op_a[i];
            b  = op_b[i];
            c  = op_c[i];
            ch = a[1:0];
            case (op_code[i])
                "W": reg_access(1'b0, a, b, rdata);
                "R":
                begin
                    reg_access(1'b1, a, 32'd0, rdata);
                    check($sformatf("register 0x%0h readback", a), rdata, b);
                end
                "B":
                begin
                    rx_words[ch].push_back(b);
                end
                "E":
                begin
                    exp_addr[ch].push_back(b[`UDMA_L2_AWIDTH-1:0]);
                    exp_data[ch].push_back(c);
                end
                "V":
                begin
                    wait_writes(ch);
                    check($sformatf("event count of channel %0d", ch), 32'(event_cnt[ch]), b);
                    event_cnt[ch] = 0;
                end
                "F":
                begin
                    @(negedge clk);
                    check("words left at the peripheral", 32'(rx_words[ch].size()), b);
                    check("rx_ready_o of a stopped channel", 32'(rx_ready[ch]), 32'd0);
                    rx_words[ch].delete();
                end
                "D": repeat (a) @(negedge clk);
                default:
                begin
                    stop_run($sformatf("Unknown operation %c in the cases file", op_code[i]));
                end
            endcase
        end

        for (int k = 0; k < N_CH; k++)
        begin
            wait_writes(udma_pkg::ch_idx_t'(k));
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/udma_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "udma_defines.svh"

module udma_core (
    input  wire logic                                   sys_clk_i,
    input  wire logic                                   reset_i,

    input  wire logic                                   cfg_valid_i,
    input  wire logic                                   cfg_rwn_i,
    input  wire udma_pkg::cfg_addr_t                    cfg_addr_i,
    input  wire udma_pkg::word_t                        cfg_wdata_i,
    output      logic                                   cfg_ready_o,
    output      udma_pkg::word_t                        cfg_rdata_o,

    input  wire logic [`UDMA_N_CH-1:0]                  rx_valid_i,
    input  wire udma_pkg::word_t [`UDMA_N_CH-1:0]       rx_data_i,
    output      logic [`UDMA_N_CH-1:0]                  rx_ready_o,
    output      logic [`UDMA_N_CH-1:0]                  events_o,

    output      logic                                   l2_req_o,
    output      udma_pkg::l2_addr_t                     l2_addr_o,
    output      udma_pkg::word_t                        l2_wdata_o,
    input  wire logic                                   l2_gnt_i
);

    udma_pkg::l2_addr_t [`UDMA_N_CH-1:0]    ch_saddr;
    udma_pkg::trans_size_t [`UDMA_N_CH-1:0] ch_size;
    logic [`UDMA_N_CH-1:0]                  ch_cont;
    logic [`UDMA_N_CH-1:0]                  ch_start;
    logic [`UDMA_N_CH-1:0]                  ch_clr;
    logic [`UDMA_N_CH-1:0]                  ch_en;
    udma_pkg::trans_size_t [`UDMA_N_CH-1:0] ch_left;

    logic [`UDMA_N_CH-1:0]                  buf_req;
    udma_pkg::l2_addr_t [`UDMA_N_CH-1:0]    buf_addr;
    udma_pkg::word_t [`UDMA_N_CH-1:0]       buf_data;
    logic [`UDMA_N_CH-1:0]                  buf_gnt;

    udma_cfg_regs i_cfg_regs (
        .sys_clk_i   ( sys_clk_i   ),
        .reset_i     ( reset_i     ),
        .cfg_valid_i ( cfg_valid_i ),
        .cfg_rwn_i   ( cfg_rwn_i   ),
        .cfg_addr_i  ( cfg_addr_i  ),
        .cfg_wdata_i ( cfg_wdata_i ),
        .cfg_ready_o ( cfg_ready_o ),
        .cfg_rdata_o ( cfg_rdata_o ),
        .ch_en_i     ( ch_en       ),
        .ch_left_i   ( ch_left     ),
        .ch_saddr_o  ( ch_saddr    ),
        .ch_size_o   ( ch_size     ),
        .ch_cont_o   ( ch_cont     ),
        .ch_start_o  ( ch_start    ),
        .ch_clr_o    ( ch_clr      )
    );

    for (genvar n = 0; n < `UDMA_N_CH; n++)
    begin : gen_ch
        udma_rx_channel i_channel (
            .sys_clk_i    ( sys_clk_i     ),
            .reset_i      ( reset_i       ),
            .cfg_saddr_i  ( ch_saddr[n]   ),
            .cfg_size_i   ( ch_size[n]    ),
            .cfg_cont_i   ( ch_cont[n]    ),
            .cfg_start_i  ( ch_start[n]   ),
            .cfg_clr_i    ( ch_clr[n]     ),
            .rx_valid_i   ( rx_valid_i[n] ),
            .rx_data_i    ( rx_data_i[n]  ),
            .rx_ready_o   ( rx_ready_o[n] ),
            .buf_req_o    ( buf_req[n]    ),
            .buf_addr_o   ( buf_addr[n]   ),
            .buf_data_o   ( buf_data[n]   ),
            .buf_gnt_i    ( buf_gnt[n]    ),
            .en_o         ( ch_en[n]      ),
            .bytes_left_o ( ch_left[n]    ),
            .event_o      ( events_o[n]   )
        );
    end

    udma_l2_arbiter i_arbiter (
        .sys_clk_i  ( sys_clk_i  ),
        .reset_i    ( reset_i    ),
        .buf_req_i  ( buf_req    ),
        .buf_addr_i ( buf_addr   ),
        .buf_data_i ( buf_data   ),
        .buf_gnt_o  ( buf_gnt    ),
        .l2_req_o   ( l2_req_o   ),
        .l2_addr_o  ( l2_addr_o  ),
        .l2_wdata_o ( l2_wdata_o ),
        .l2_gnt_i   ( l2_gnt_i   )
    );

endmodule

`default_nettype wire

// ==== rtl/udma_l2_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "udma_defines.svh"

module udma_l2_arbiter (
    input  wire logic                                   sys_clk_i,
    input  wire logic                                   reset_i,

    input  wire logic [`UDMA_N_CH-1:0]                  buf_req_i,
    input  wire udma_pkg::l2_addr_t [`UDMA_N_CH-1:0]    buf_addr_i,
    input  wire udma_pkg::word_t [`UDMA_N_CH-1:0]       buf_data_i,
    output      logic [`UDMA_N_CH-1:0]                  buf_gnt_o,

    output      logic                                   l2_req_o,
    output      udma_pkg::l2_addr_t                     l2_addr_o,
    output      udma_pkg::word_t                        l2_wdata_o,
    input  wire logic                                   l2_gnt_i
);

    udma_pkg::ch_idx_t last_q;
    udma_pkg::ch_idx_t lock_idx_q;
    logic              lock_q;
    udma_pkg::ch_idx_t rr_idx;
    udma_pkg::ch_idx_t sel;

    // Search starts one past the last granted channel and wraps around
    always_comb
    begin
        udma_pkg::ch_idx_t cand;
        logic              found;
        rr_idx = last_q;
        found  = 1'b0;
        for (int i = 1; i <= `UDMA_N_CH; i++)
        begin
            cand = udma_pkg::ch_idx_t'((int'(last_q) + i) % `UDMA_N_CH);
            if (!found && buf_req_i[cand])
            begin
                rr_idx = cand;
                found  = 1'b1;
            end
        end
    end

    assign sel        = lock_q ? lock_idx_q : rr_idx;
    assign l2_req_o   = buf_req_i[sel];
    assign l2_addr_o  = buf_addr_i[sel];
    assign l2_wdata_o = buf_data_i[sel];

    always_comb
    begin
        buf_gnt_o      = '0;
        buf_gnt_o[sel] = l2_req_o && l2_gnt_i;
    end

    // A pending request pins the selection until L2 grants it
    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            last_q     <= udma_pkg::ch_idx_t'(`UDMA_N_CH - 1);
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end
        else
        begin
            lock_q     <= l2_req_o && !l2_gnt_i;
            lock_idx_q <= sel;
            if (l2_req_o && l2_gnt_i)
            begin
                last_q <= sel;
            end
        end
    end

    a_gnt_onehot: assert property (
        @(posedge sys_clk_i) disable iff (reset_i)
        $onehot0(buf_gnt_o)
    );

endmodule

`default_nettype wire

// ==== rtl/udma_rx_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "udma_defines.svh"

module udma_rx_channel (
    input  wire logic                   sys_clk_i,
    input  wire logic                   reset_i,

    input  wire udma_pkg::l2_addr_t     cfg_saddr_i,
    input  wire udma_pkg::trans_size_t  cfg_size_i,
    input  wire logic                   cfg_cont_i,
    input  wire logic                   cfg_start_i,
    input  wire logic                   cfg_clr_i,

    input  wire logic                   rx_valid_i,
    input  wire udma_pkg::word_t        rx_data_i,
    output      logic                   rx_ready_o,

    output      logic                   buf_req_o,
    output      udma_pkg::l2_addr_t     buf_addr_o,
    output      udma_pkg::word_t        buf_data_o,
    input  wire logic                   buf_gnt_i,

    output      logic                   en_o,
    output      udma_pkg::trans_size_t  bytes_left_o,
    output      logic                   event_o
);

    udma_pkg::chan_state_e state_q;
    udma_pkg::l2_addr_t    curr_addr_q;
    logic                  buf_last_q;
    logic                  capture;
    logic                  is_last;

    assign en_o       = (state_q == udma_pkg::CH_RUN);
    // The buffer slot frees up in the same cycle its word is granted
    assign rx_ready_o = en_o && (!buf_req_o || buf_gnt_i);
    assign capture    = rx_valid_i && rx_ready_o;
    assign is_last    = (bytes_left_o == udma_pkg::trans_size_t'(`UDMA_BEAT_BYTES));

    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i || cfg_clr_i)
        begin
            state_q      <= udma_pkg::CH_IDLE;
            bytes_left_o <= '0;
        end
        else if (state_q == udma_pkg::CH_IDLE)
        begin
            if (cfg_start_i)
            begin
                state_q      <= udma_pkg::CH_RUN;
                curr_addr_q  <= cfg_saddr_i;
                bytes_left_o <= cfg_size_i;
            end
        end
        else if (capture)
        begin
            if (!is_last)
            begin
                curr_addr_q  <= curr_addr_q + udma_pkg::l2_addr_t'(`UDMA_BEAT_BYTES);
                bytes_left_o <= bytes_left_o - udma_pkg::trans_size_t'(`UDMA_BEAT_BYTES);
            end
            else if (cfg_cont_i)
            begin
                curr_addr_q  <= cfg_saddr_i;
                bytes_left_o <= cfg_size_i;
            end
            else
            begin
                state_q      <= udma_pkg::CH_IDLE;
                bytes_left_o <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // One-word buffer towards the arbiter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i || cfg_clr_i)
        begin
            buf_req_o <= 1'b0;
        end
        else if (capture)
        begin
            buf_req_o <= 1'b1;
        end
        else if (buf_gnt_i)
        begin
            buf_req_o <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (capture)
        begin
            buf_addr_o <= curr_addr_q;
            buf_data_o <= rx_data_i;
            buf_last_q <= is_last;
        end
    end

    // End of transfer is signalled once the last word has left for L2
    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            event_o <= 1'b0;
        end
        else
        begin
            event_o <= buf_gnt_i && buf_last_q;
        end
    end

    a_buf_stable: assert property (
        @(posedge sys_clk_i) disable iff (reset_i)
        buf_req_o && !buf_gnt_i && !cfg_clr_i |=>
            buf_req_o && $stable(buf_addr_o) && $stable(buf_data_o)
    );

endmodule

`default_nettype wire

// ==== rtl/udma_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "udma_defines.svh"

module udma_cfg_regs (
    input  wire logic                                       sys_clk_i,
    input  wire logic                                       reset_i,

    input  wire logic                                       cfg_valid_i,
    input  wire logic                                       cfg_rwn_i,
    input  wire udma_pkg::cfg_addr_t                        cfg_addr_i,
    input  wire udma_pkg::word_t                            cfg_wdata_i,
    output      logic                                       cfg_ready_o,
    output      udma_pkg::word_t                            cfg_rdata_o,

    input  wire logic [`UDMA_N_CH-1:0]                      ch_en_i,
    input  wire udma_pkg::trans_size_t [`UDMA_N_CH-1:0]     ch_left_i,
    output      udma_pkg::l2_addr_t [`UDMA_N_CH-1:0]        ch_saddr_o,
    output      udma_pkg::trans_size_t [`UDMA_N_CH-1:0]     ch_size_o,
    output      logic [`UDMA_N_CH-1:0]                      ch_cont_o,
    output      logic [`UDMA_N_CH-1:0]                      ch_start_o,
    output      logic [`UDMA_N_CH-1:0]                      ch_clr_o
);

    udma_pkg::ch_idx_t ch_sel;
    logic [1:0]        reg_sel;
    logic              wr_en;

    assign ch_sel  = cfg_addr_i[3:2];
    assign reg_sel = cfg_addr_i[1:0];
    assign wr_en   = cfg_valid_i && cfg_ready_o && !cfg_rwn_i;

    ////////////////////////////////////////////////////////////
    // Handshake and register storage
    ////////////////////////////////////////////////////////////

    // Ready answers every valid one cycle later and drops right after
    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            cfg_ready_o <= 1'b0;
        end
        else
        begin
            cfg_ready_o <= cfg_valid_i && !cfg_ready_o;
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (wr_en && reg_sel == `UDMA_REG_SADDR)
        begin
            ch_saddr_o[ch_sel] <= cfg_wdata_i[`UDMA_L2_AWIDTH-1:0];
        end
        if (wr_en && reg_sel == `UDMA_REG_SIZE)
        begin
            ch_size_o[ch_sel] <= cfg_wdata_i[`UDMA_TRANS_SIZE-1:0];
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (reset_i)
        begin
            ch_cont_o <= '0;
        end
        else if (wr_en && reg_sel == `UDMA_REG_CFG)
        begin
            ch_cont_o[ch_sel] <= cfg_wdata_i[`UDMA_CFG_CONT_BIT];
        end
    end

    // Start and clear act on the same edge as the CFG write
    always_comb
    begin
        ch_start_o = '0;
        ch_clr_o   = '0;
        if (wr_en && reg_sel == `UDMA_REG_CFG)
        begin
            ch_start_o[ch_sel] = cfg_wdata_i[`UDMA_CFG_EN_BIT];
            ch_clr_o[ch_sel]   = cfg_wdata_i[`UDMA_CFG_CLR_BIT];
        end
    end

    ////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        cfg_rdata_o = '0;
        case (reg_sel)
            `UDMA_REG_SADDR: cfg_rdata_o[`UDMA_L2_AWIDTH-1:0]  = ch_saddr_o[ch_sel];
            `UDMA_REG_SIZE:  cfg_rdata_o[`UDMA_TRANS_SIZE-1:0] = ch_size_o[ch_sel];
            `UDMA_REG_CFG:
            begin
                cfg_rdata_o[`UDMA_CFG_CONT_BIT] = ch_cont_o[ch_sel];
                cfg_rdata_o[`UDMA_CFG_EN_BIT]   = ch_en_i[ch_sel];
            end
            default:         cfg_rdata_o[`UDMA_TRANS_SIZE-1:0] = ch_left_i[ch_sel];
        endcase
    end

    a_ready_after_valid: assert property (
        @(posedge sys_clk_i) disable iff (reset_i)
        $rose(cfg_ready_o) |-> $past(cfg_valid_i)
    );

endmodule

`default_nettype wire

// ==== rtl/udma_pkg.sv ====
`default_nettype none

`include "udma_defines.svh"

package udma_pkg;

    typedef logic [`UDMA_DATA_WIDTH-1:0]     word_t;
    typedef logic [`UDMA_L2_AWIDTH-1:0]      l2_addr_t;
    typedef logic [`UDMA_TRANS_SIZE-1:0]     trans_size_t;
    typedef logic [`UDMA_CFG_AWIDTH-1:0]     cfg_addr_t;
    typedef logic [$clog2(`UDMA_N_CH)-1:0]   ch_idx_t;

    typedef enum logic {
        CH_IDLE,
        CH_RUN
    } chan_state_e;

endpackage

`default_nettype wire

// ==== rtl/udma_defines.svh ====
`ifndef UDMA_DEFINES_SVH
`define UDMA_DEFINES_SVH

// Channel count and datapath widths
`define UDMA_N_CH           4
`define UDMA_DATA_WIDTH     32
`define UDMA_L2_AWIDTH      16
`define UDMA_TRANS_SIZE     16
`define UDMA_BEAT_BYTES     4

// Register word address, bits [3:2] pick the channel and bits [1:0] the register
`define UDMA_CFG_AWIDTH     4

`define UDMA_REG_SADDR      2'd0
`define UDMA_REG_SIZE       2'd1
`define UDMA_REG_CFG        2'd2
`define UDMA_REG_LEFT       2'd3

// Bit positions inside the CFG register
`define UDMA_CFG_CONT_BIT   0
`define UDMA_CFG_EN_BIT     4
`define UDMA_CFG_CLR_BIT    6

`endif
